//--- Bender.yml
package:
  name: mhp

sources:
  - verilog/mhp_pkg.sv
  - verilog/frame_buffer.sv
  - verilog/rx_loader.sv
  - verilog/header_parser.sv
  - verilog/reply_builder.sv
  - verilog/checksum_unit.sv
  - verilog/tx_streamer.sv
  - verilog/msg_control.sv
  - verilog/mhp_top.sv
  - target: simulation
    files:
      - bench/mhp_tb.sv

//--- bench/mhp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mhp_tb import mhp_pkg::*;;

  localparam int          RX_GAP        = 16;
  localparam logic [31:0] SEED          = 32'h224a;
  localparam int          REPLY_TIMEOUT = 6000;
  localparam int          DROP_WINDOW   = 400;
  localparam int          TAIL_WINDOW   = 24;

  logic       i_clk;
  logic       i_rst;
  logic [7:0] i_rdata;
  logic       i_rready;
  logic       o_rreq;
  logic [7:0] o_wdata;
  logic       o_wvalid;
  logic       i_wready;

  logic [31:0] stim_seed;
  logic [31:0] bp_seed;
  logic        bp_mode;
  logic        rx_guard;
  logic        pop_pending;

  // fifo contents, collected reply, current request and its model reply
  logic [7:0] rx_q[$];
  logic [7:0] tx_q[$];
  logic [7:0] frame_q[$];
  logic [7:0] model_q[$];
  logic [7:0] exp_q[$];

  mhp_top #(
    .RX_GAP (RX_GAP)
  ) i_mhp_top (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_rdata  (i_rdata),
    .i_rready (i_rready),
    .o_rreq   (o_rreq),
    .o_wdata  (o_wdata),
    .o_wvalid (o_wvalid),
    .i_wready (i_wready)
  );

  always #10 i_clk = ~i_clk;

  //////////////////////////////
  // helpers
  //////////////////////////////
  function automatic logic [31:0] lcg_step(input logic [31:0] st);
    return st * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [15:0] next_rand();
    stim_seed = lcg_step(stim_seed);
    return stim_seed[31:16];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  //////////////////////////////
  // fifo and port models
  //////////////////////////////
  // requests seen mid-cycle, answered after the next edge
  always @(negedge i_clk) begin
    if (i_rst) begin
      check_value("o_rreq", o_rreq, 1'b0);
      check_value("o_wvalid", o_wvalid, 1'b0);
    end else begin
      if (o_wvalid) begin
        check_value("i_wready", i_wready, 1'b1);
        tx_q.push_back(o_wdata);
      end
      if (o_rreq) begin
        if (rx_guard) begin
          check_value("o_rreq", o_rreq, 1'b0);
        end
        pop_pending = 1'b1;
      end
    end
  end

  always @(posedge i_clk) begin
    #1;
    if (pop_pending && rx_q.size() == 0) begin
      abort_run("receive request while the FIFO model was empty");
    end else begin
      if (pop_pending) begin
        i_rdata     = rx_q.pop_front();
        pop_pending = 1'b0;
      end
      i_rready = (rx_q.size() != 0);
      if (bp_mode) begin
        bp_seed  = lcg_step(bp_seed);
        i_wready = bp_seed[29];
      end else begin
        i_wready = 1'b1;
      end
    end
  end

  //////////////////////////////
  // reference model
  //////////////////////////////
  // request into frame_q, expected answer into model_q
  task automatic make_frame(input logic [7:0] dtype, input int plen, input int size_err);
    logic [15:0] src;
    logic [15:0] dst;
    logic [15:0] size;
    logic [15:0] sum;
    logic [7:0]  data;
    int          i;
    src  = next_rand();
    dst  = next_rand();
    size = 16'(plen + size_err);
    frame_q.delete();
    model_q.delete();
    frame_q.push_back(src[15:8]);
    frame_q.push_back(src[7:0]);
    frame_q.push_back(dst[15:8]);
    frame_q.push_back(dst[7:0]);
    frame_q.push_back(size[15:8]);
    frame_q.push_back(size[7:0]);
    frame_q.push_back(dtype);
    // answer goes back to the sender
    model_q.push_back(dst[15:8]);
    model_q.push_back(dst[7:0]);
    model_q.push_back(src[15:8]);
    model_q.push_back(src[7:0]);
    if (dtype == TYPE_PING) begin
      model_q.push_back(8'h00);
      model_q.push_back(8'h00);
    end else begin
      model_q.push_back(size[15:8]);
      model_q.push_back(size[7:0]);
    end
    model_q.push_back(dtype | REPLY_BIT);
    for (i = 0; i < plen; i++) begin
      data = 8'(next_rand());
      frame_q.push_back(data);
      if (dtype == TYPE_ECHO) begin
        model_q.push_back(data);
      end
    end
    sum = 16'h0000;
    for (i = 0; i < model_q.size(); i++) begin
      sum = sum + {8'h00, model_q[i]};
    end
    model_q.push_back(sum[15:8]);
    model_q.push_back(sum[7:0]);
  endtask

  task automatic push_frame();
    int i;
    for (i = 0; i < frame_q.size(); i++) begin
      rx_q.push_back(frame_q[i]);
    end
  endtask

  //////////////////////////////
  // waits and checks
  //////////////////////////////
  task automatic wait_bytes(input int count);
    int cycles;
    cycles = 0;
    while (tx_q.size() < count) begin
      if (cycles == REPLY_TIMEOUT) begin
        abort_run($sformatf("timeout: only %0d of %0d reply bytes arrived",
                            tx_q.size(), count));
      end else begin
        @(posedge i_clk);
        cycles++;
      end
    end
  endtask

  task automatic check_reply();
    int i;
    int cycles;
    // a surplus byte would show up here
    for (cycles = 0; cycles < TAIL_WINDOW; cycles++) begin
      @(posedge i_clk);
    end
    check_value("reply length", tx_q.size(), exp_q.size());
    for (i = 0; i < exp_q.size(); i++) begin
      check_value($sformatf("o_wdata[%0d]", i), tx_q[i], exp_q[i]);
    end
    tx_q.delete();
  endtask

  task automatic expect_silence();
    int cycles;
    for (cycles = 0; cycles < DROP_WINDOW; cycles++) begin
      @(posedge i_clk);
      if (tx_q.size() != 0) begin
        abort_run("a reply was sent for a frame that should have been dropped");
      end
    end
    if (rx_q.size() != 0) begin
      abort_run("the dropped frame was not read completely from the FIFO");
    end
  endtask

  task automatic run_reply(input logic [7:0] dtype);
    make_frame(dtype, int'(next_rand() % 16'd41), 0);
    push_frame();
    exp_q = model_q;
    wait_bytes(exp_q.size());
    check_reply();
  endtask

  // second frame arrives while the first answer is still going out
  task automatic run_back_to_back(input logic [7:0] first_type,
                                  input logic [7:0] second_type);
    make_frame(first_type, int'(next_rand() % 16'd41), 0);
    push_frame();
    exp_q = model_q;
    wait_bytes(1);
    make_frame(second_type, int'(next_rand() % 16'd41), 0);
    push_frame();
    rx_guard = 1'b1;
    wait_bytes(exp_q.size());
    rx_guard = 1'b0;
    check_reply();
    exp_q = model_q;
    wait_bytes(exp_q.size());
    check_reply();
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin
    logic [7:0] odd_type;
    int         n;
    int         k;
    i_clk       = 1'b0;
    i_rst       = 1'b1;
    i_rdata     = 8'h00;
    i_rready    = 1'b0;
    i_wready    = 1'b1;
    bp_mode     = 1'b0;
    rx_guard    = 1'b0;
    pop_pending = 1'b0;
    stim_seed   = SEED;
    bp_seed     = {next_rand(), next_rand()};

    repeat (5) @(posedge i_clk);
    #1 i_rst = 1'b0;
    repeat (5) begin
      @(negedge i_clk);
      check_value("o_rreq", o_rreq, 1'b0);
      check_value("o_wvalid", o_wvalid, 1'b0);
    end
    @(posedge i_clk);

    // ping and echo with full readiness
    repeat (3) run_reply(TYPE_PING);
    repeat (4) run_reply(TYPE_ECHO);

    // unknown type
    odd_type = 8'(next_rand());
    if (odd_type == TYPE_PING || odd_type == TYPE_ECHO) begin
      odd_type = 8'h02;
    end
    make_frame(odd_type, int'(next_rand() % 16'd41), 0);
    push_frame();
    expect_silence();

    // size field one larger than the payload
    make_frame(TYPE_ECHO, int'(next_rand() % 16'd41), 1);
    push_frame();
    expect_silence();

    // shorter than a header
    frame_q.delete();
    n = 1 + int'(next_rand() % 16'd6);
    for (k = 0; k < n; k++) begin
      frame_q.push_back(8'(next_rand()));
    end
    push_frame();
    expect_silence();
    run_reply(TYPE_PING);

    // random back-pressure on the transmit port
    bp_mode = 1'b1;
    repeat (4) run_reply(TYPE_ECHO);
    run_reply(TYPE_PING);

    run_back_to_back(TYPE_ECHO, TYPE_PING);
    bp_mode = 1'b0;
    run_back_to_back(TYPE_PING, TYPE_ECHO);

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
verilog/mhp_pkg.sv
verilog/frame_buffer.sv
verilog/rx_loader.sv
verilog/header_parser.sv
verilog/reply_builder.sv
verilog/checksum_unit.sv
verilog/tx_streamer.sv
verilog/msg_control.sv
verilog/mhp_top.sv
bench/mhp_tb.sv

//--- verilog/checksum_unit.sv
`timescale 1ns/1ps
`default_nettype none

module checksum_unit import mhp_pkg::*; (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_start,
  input  logic [FRAME_AW-1:0] i_len,
  input  logic [7:0]          i_rdata,
  output mem_req_t            o_req,
  output logic                o_done
);

  typedef enum logic [1:0] {S_IDLE, S_READ, S_HI, S_LO} state_e;

  state_e              state;
  logic [FRAME_AW-1:0] rd_idx;
  // read issued last cycle, byte now on i_rdata
  logic                pend;
  logic [15:0]         sum;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= S_IDLE;
      rd_idx <= '0;
      pend   <= 1'b0;
      sum    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            rd_idx <= '0;
            pend   <= 1'b0;
            sum    <= '0;
            state  <= S_READ;
          end
        end
        // one read per cycle, sum trails by one
        S_READ: begin
          if (pend) begin
            sum <= sum + {8'h00, i_rdata};
          end
          if (rd_idx == i_len) begin
            pend  <= 1'b0;
            state <= S_HI;
          end else begin
            rd_idx <= rd_idx + 1'b1;
            pend   <= 1'b1;
          end
        end
        S_HI: state <= S_LO;
        S_LO: begin
          o_done <= 1'b1;
          state  <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_comb begin
    o_req.addr  = rd_idx;
    o_req.we    = 1'b0;
    o_req.wdata = '0;
    case (state)
      S_HI: begin
        o_req.addr  = i_len;
        o_req.we    = 1'b1;
        o_req.wdata = sum[15:8];
      end
      S_LO: begin
        o_req.addr  = i_len + 1'b1;
        o_req.we    = 1'b1;
        o_req.wdata = sum[7:0];
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer import mhp_pkg::*; (
  input  logic       i_clk,
  input  owner_e     i_owner,
  input  mem_req_t   i_rx_req,
  input  mem_req_t   i_parse_req,
  input  mem_req_t   i_build_req,
  input  mem_req_t   i_sum_req,
  input  mem_req_t   i_tx_req,
  output logic [7:0] o_rdata
);

  logic [7:0] mem [FRAME_SIZE];
  mem_req_t   sel_req;

  // only the current owner reaches the port
  always_comb begin
    case (i_owner)
      OWN_PARSE: sel_req = i_parse_req;
      OWN_BUILD: sel_req = i_build_req;
      OWN_SUM:   sel_req = i_sum_req;
      OWN_TX:    sel_req = i_tx_req;
      default:   sel_req = i_rx_req;
    endcase
  end

  // read returns the old byte on a write cycle
  always_ff @(posedge i_clk) begin
    if (sel_req.we) begin
      mem[sel_req.addr] <= sel_req.wdata;
    end
    o_rdata <= mem[sel_req.addr];
  end

  // parser and streamer only read
  a_write_owner: assert property (@(posedge i_clk)
    sel_req.we |-> (i_owner inside {OWN_RX, OWN_BUILD, OWN_SUM}));

endmodule

`default_nettype wire

//--- verilog/header_parser.sv
`timescale 1ns/1ps
`default_nettype none

module header_parser import mhp_pkg::*; (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_start,
  input  logic [7:0]          i_rdata,
  input  logic [FRAME_AW-1:0] i_len,
  output mem_req_t            o_req,
  output frame_hdr_t          o_hdr,
  output logic                o_len_ok,
  output logic                o_done
);

  logic        busy;
  logic        phase;
  logic [2:0]  idx;
  logic [16:0] hdr_plus_size;

  // address 0 is already on the port in the start cycle
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy   <= 1'b0;
      phase  <= 1'b0;
      idx    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy  <= 1'b1;
        phase <= 1'b1;
        idx   <= '0;
      end else if (busy) begin
        phase <= !phase;
        if (phase) begin
          if (idx == 3'd6) begin
            busy   <= 1'b0;
            idx    <= '0;
            o_done <= 1'b1;
          end else begin
            idx <= idx + 1'b1;
          end
        end
      end
    end
  end

  // bytes shift in msb first
  always_ff @(posedge i_clk) begin
    if (busy && phase) begin
      o_hdr <= {o_hdr[$bits(frame_hdr_t)-9:0], i_rdata};
    end
  end

  always_comb begin
    o_req.addr  = FRAME_AW'(idx);
    o_req.we    = 1'b0;
    o_req.wdata = '0;
  end

  assign hdr_plus_size = 17'(HDR_LEN) + {1'b0, o_hdr.size};
  assign o_len_ok = (i_len >= FRAME_AW'(HDR_LEN)) && ({6'b0, i_len} == hdr_plus_size);

endmodule

`default_nettype wire

//--- verilog/mhp_pkg.sv
`default_nettype none

package mhp_pkg;

  //////////////////////////////
  // buffer geometry
  //////////////////////////////
  localparam int FRAME_AW   = 11;
  localparam int FRAME_SIZE = 1 << FRAME_AW;

  //////////////////////////////
  // message layout and types
  //////////////////////////////
  // src, dst, size, type
  localparam int HDR_LEN = 7;

  localparam logic [7:0] TYPE_PING = 8'h01;
  localparam logic [7:0] TYPE_ECHO = 8'h05;
  // set in the type byte of every answer
  localparam logic [7:0] REPLY_BIT = 8'h80;

  // big-endian on the wire, src first
  typedef struct packed {
    logic [15:0] src;
    logic [15:0] dst;
    logic [15:0] size;
    logic [7:0]  dtype;
  } frame_hdr_t;

  // one buffer access from a datapath unit
  typedef struct packed {
    logic [FRAME_AW-1:0] addr;
    logic                we;
    logic [7:0]          wdata;
  } mem_req_t;

  // who drives the buffer port
  typedef enum logic [2:0] {
    OWN_RX,
    OWN_PARSE,
    OWN_BUILD,
    OWN_SUM,
    OWN_TX
  } owner_e;

endpackage

`default_nettype wire

//--- verilog/mhp_top.sv
`timescale 1ns/1ps
`default_nettype none

module mhp_top import mhp_pkg::*; #(
  parameter int RX_GAP = 63
) (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic [7:0] i_rdata,
  input  logic       i_rready,
  output logic       o_rreq,
  output logic [7:0] o_wdata,
  output logic       o_wvalid,
  input  logic       i_wready
);

  owner_e              owner;
  mem_req_t            rx_req;
  mem_req_t            parse_req;
  mem_req_t            build_req;
  mem_req_t            sum_req;
  mem_req_t            tx_req;
  logic [7:0]          buf_rdata;
  logic                rx_start;
  logic                rx_done;
  logic                parse_start;
  logic                parse_done;
  logic                build_start;
  logic                build_done;
  logic                sum_start;
  logic                sum_done;
  logic                tx_start;
  logic                tx_done;
  logic [FRAME_AW-1:0] rx_len;
  logic [FRAME_AW-1:0] reply_len;
  frame_hdr_t          parsed_hdr;
  frame_hdr_t          reply_hdr;
  logic                len_ok;

  msg_control i_msg_control (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_rx_done     (rx_done),
    .i_parse_done  (parse_done),
    .i_build_done  (build_done),
    .i_sum_done    (sum_done),
    .i_tx_done     (tx_done),
    .i_len         (rx_len),
    .i_hdr         (parsed_hdr),
    .i_len_ok      (len_ok),
    .o_owner       (owner),
    .o_rx_start    (rx_start),
    .o_parse_start (parse_start),
    .o_build_start (build_start),
    .o_sum_start   (sum_start),
    .o_tx_start    (tx_start),
    .o_hdr         (reply_hdr),
    .o_reply_len   (reply_len)
  );

  frame_buffer i_frame_buffer (
    .i_clk       (i_clk),
    .i_owner     (owner),
    .i_rx_req    (rx_req),
    .i_parse_req (parse_req),
    .i_build_req (build_req),
    .i_sum_req   (sum_req),
    .i_tx_req    (tx_req),
    .o_rdata     (buf_rdata)
  );

  rx_loader #(
    .RX_GAP (RX_GAP)
  ) i_rx_loader (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_start  (rx_start),
    .i_rdata  (i_rdata),
    .i_rready (i_rready),
    .o_rreq   (o_rreq),
    .o_req    (rx_req),
    .o_len    (rx_len),
    .o_done   (rx_done)
  );

  header_parser i_header_parser (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_start  (parse_start),
    .i_rdata  (buf_rdata),
    .i_len    (rx_len),
    .o_req    (parse_req),
    .o_hdr    (parsed_hdr),
    .o_len_ok (len_ok),
    .o_done   (parse_done)
  );

  reply_builder i_reply_builder (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (build_start),
    .i_hdr   (reply_hdr),
    .o_req   (build_req),
    .o_done  (build_done)
  );

  checksum_unit i_checksum_unit (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (sum_start),
    .i_len   (reply_len),
    .i_rdata (buf_rdata),
    .o_req   (sum_req),
    .o_done  (sum_done)
  );

  tx_streamer i_tx_streamer (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_start  (tx_start),
    .i_len    (reply_len),
    .i_rdata  (buf_rdata),
    .i_wready (i_wready),
    .o_req    (tx_req),
    .o_wdata  (o_wdata),
    .o_wvalid (o_wvalid),
    .o_done   (tx_done)
  );

endmodule

`default_nettype wire

//--- verilog/msg_control.sv
`timescale 1ns/1ps
`default_nettype none

module msg_control import mhp_pkg::*; (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_rx_done,
  input  logic                i_parse_done,
  input  logic                i_build_done,
  input  logic                i_sum_done,
  input  logic                i_tx_done,
  input  logic [FRAME_AW-1:0] i_len,
  input  frame_hdr_t          i_hdr,
  input  logic                i_len_ok,
  output owner_e              o_owner,
  output logic                o_rx_start,
  output logic                o_parse_start,
  output logic                o_build_start,
  output logic                o_sum_start,
  output logic                o_tx_start,
  output frame_hdr_t          o_hdr,
  output logic [FRAME_AW-1:0] o_reply_len
);

  typedef enum logic [2:0] {
    P_BOOT, P_RX, P_PARSE, P_DECIDE, P_BUILD, P_SUM, P_TX
  } phase_e;

  phase_e phase;
  logic   is_ping;
  logic   is_echo;

  assign is_ping = (i_hdr.dtype == TYPE_PING);
  assign is_echo = (i_hdr.dtype == TYPE_ECHO);

  //////////////////////////////
  // phase sequencer
  //////////////////////////////
  // owner and start change on the same edge
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      phase         <= P_BOOT;
      o_owner       <= OWN_RX;
      o_rx_start    <= 1'b0;
      o_parse_start <= 1'b0;
      o_build_start <= 1'b0;
      o_sum_start   <= 1'b0;
      o_tx_start    <= 1'b0;
    end else begin
      o_rx_start    <= 1'b0;
      o_parse_start <= 1'b0;
      o_build_start <= 1'b0;
      o_sum_start   <= 1'b0;
      o_tx_start    <= 1'b0;
      case (phase)
        P_BOOT: begin
          o_owner    <= OWN_RX;
          o_rx_start <= 1'b1;
          phase      <= P_RX;
        end
        P_RX: begin
          if (i_rx_done) begin
            o_owner       <= OWN_PARSE;
            o_parse_start <= 1'b1;
            phase         <= P_PARSE;
          end
        end
        P_PARSE: begin
          if (i_parse_done) begin
            phase <= P_DECIDE;
          end
        end
        // malformed or unknown frames go straight back to receive
        P_DECIDE: begin
          if (i_len_ok && (is_ping || is_echo)) begin
            o_owner       <= OWN_BUILD;
            o_build_start <= 1'b1;
            phase         <= P_BUILD;
          end else begin
            o_owner    <= OWN_RX;
            o_rx_start <= 1'b1;
            phase      <= P_RX;
          end
        end
        P_BUILD: begin
          if (i_build_done) begin
            o_owner     <= OWN_SUM;
            o_sum_start <= 1'b1;
            phase       <= P_SUM;
          end
        end
        P_SUM: begin
          if (i_sum_done) begin
            o_owner    <= OWN_TX;
            o_tx_start <= 1'b1;
            phase      <= P_TX;
          end
        end
        P_TX: begin
          if (i_tx_done) begin
            o_owner    <= OWN_RX;
            o_rx_start <= 1'b1;
            phase      <= P_RX;
          end
        end
        default: phase <= P_BOOT;
      endcase
    end
  end

  // header and reply length, captured at the decision
  // echo length equals the received length once it checks out
  always_ff @(posedge i_clk) begin
    if (phase == P_DECIDE) begin
      o_hdr       <= i_hdr;
      o_reply_len <= is_ping ? FRAME_AW'(HDR_LEN) : i_len;
    end
  end

endmodule

`default_nettype wire

//--- verilog/reply_builder.sv
`timescale 1ns/1ps
`default_nettype none

module reply_builder import mhp_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_start,
  input  frame_hdr_t i_hdr,
  output mem_req_t   o_req,
  output logic       o_done
);

  logic        busy;
  logic        phase;
  logic [2:0]  idx;
  logic [15:0] reply_size;
  logic [55:0] reply_word;

  // ping answers carry no payload
  assign reply_size = (i_hdr.dtype == TYPE_PING) ? 16'h0000 : i_hdr.size;
  // addresses swapped
  assign reply_word = {i_hdr.dst, i_hdr.src, reply_size, i_hdr.dtype | REPLY_BIT};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy   <= 1'b0;
      phase  <= 1'b0;
      idx    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy  <= 1'b1;
        phase <= 1'b1;
        idx   <= '0;
      end else if (busy) begin
        phase <= !phase;
        if (phase) begin
          if (idx == 3'd6) begin
            busy   <= 1'b0;
            idx    <= '0;
            o_done <= 1'b1;
          end else begin
            idx <= idx + 1'b1;
          end
        end
      end
    end
  end

  always_comb begin
    o_req.addr  = FRAME_AW'(idx);
    o_req.we    = busy && phase;
    o_req.wdata = reply_word[8 * (6 - int'(idx)) +: 8];
  end

endmodule

`default_nettype wire

//--- verilog/rx_loader.sv
`timescale 1ns/1ps
`default_nettype none

module rx_loader import mhp_pkg::*; #(
  parameter int RX_GAP = 63
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_start,
  input  logic [7:0]          i_rdata,
  input  logic                i_rready,
  output logic                o_rreq,
  output mem_req_t            o_req,
  output logic [FRAME_AW-1:0] o_len,
  output logic                o_done
);

  localparam int GAP_W = $clog2(RX_GAP + 1);

  typedef enum logic [2:0] {S_IDLE, S_ARM, S_REQ, S_CAP, S_GAP} state_e;

  state_e              state;
  logic [GAP_W-1:0]    gap_cnt;
  logic [FRAME_AW-1:0] wr_addr;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= S_IDLE;
      gap_cnt <= '0;
      wr_addr <= '0;
      o_done  <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            wr_addr <= '0;
            state   <= S_ARM;
          end
        end
        // no gap counting before the first byte
        S_ARM: begin
          if (i_rready) begin
            state <= S_REQ;
          end
        end
        S_REQ: state <= S_CAP;
        // byte is on i_rdata this cycle
        S_CAP: begin
          wr_addr <= wr_addr + 1'b1;
          gap_cnt <= GAP_W'(1);
          state   <= i_rready ? S_REQ : S_GAP;
        end
        S_GAP: begin
          if (i_rready) begin
            state <= S_REQ;
          end else if (gap_cnt == GAP_W'(RX_GAP - 1)) begin
            o_done <= 1'b1;
            state  <= S_IDLE;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign o_rreq = (state == S_REQ);
  assign o_len  = wr_addr;

  always_comb begin
    o_req.addr  = wr_addr;
    o_req.we    = (state == S_CAP);
    o_req.wdata = i_rdata;
  end

endmodule

`default_nettype wire

//--- verilog/tx_streamer.sv
`timescale 1ns/1ps
`default_nettype none

module tx_streamer import mhp_pkg::*; (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_start,
  input  logic [FRAME_AW-1:0] i_len,
  input  logic [7:0]          i_rdata,
  input  logic                i_wready,
  output mem_req_t            o_req,
  output logic [7:0]          o_wdata,
  output logic                o_wvalid,
  output logic                o_done
);

  typedef enum logic [1:0] {S_IDLE, S_ADDR, S_LOAD, S_SEND} state_e;

  state_e              state;
  logic [FRAME_AW-1:0] idx;
  logic [FRAME_AW-1:0] last_idx;
  logic [7:0]          data_q;

  // two checksum bytes follow the reply
  assign last_idx = i_len + 1'b1;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= S_IDLE;
      idx    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            idx   <= '0;
            state <= S_ADDR;
          end
        end
        S_ADDR: state <= S_LOAD;
        S_LOAD: state <= S_SEND;
        // hold the byte until the port takes it
        S_SEND: begin
          if (i_wready) begin
            if (idx == last_idx) begin
              o_done <= 1'b1;
              state  <= S_IDLE;
            end else begin
              idx   <= idx + 1'b1;
              state <= S_ADDR;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == S_LOAD) begin
      data_q <= i_rdata;
    end
  end

  always_comb begin
    o_req.addr  = idx;
    o_req.we    = 1'b0;
    o_req.wdata = '0;
  end

  assign o_wdata  = data_q;
  assign o_wvalid = (state == S_SEND) && i_wready;

endmodule

`default_nettype wire
